// File: logic/raster_pkg.sv
/* Line rasterizer shared types */

package raster_pkg;

	// screen x coordinate, also the offset along a line
	typedef logic [9:0] coord_t;

	// frame buffer row, 480 lines fit in 9 bits
	typedef logic [8:0] row_t;

	// 3-bit palette index
	typedef logic [2:0] color_t;

	// signed line delta, dx or dy
	typedef logic signed [10:0] delta_t;

	// octant tag, passed through for the frame buffer mirror
	typedef logic [2:0] octant_t;

	// one packed line record as written into the queue
	typedef logic [68:0] line_rec_t;

	// record field positions, lsb of each field
	// x_init  68..59
	localparam int REC_X_INIT_LSB = 59;
	// y_init  58..49, kept at coordinate width in the record
	localparam int REC_Y_INIT_LSB = 49;
	// x_final 48..39
	localparam int REC_X_FINAL_LSB = 39;
	// y_final 38..29
	localparam int REC_Y_FINAL_LSB = 29;
	// dy      28..18
	localparam int REC_DY_LSB = 18;
	// dx      17..7
	localparam int REC_DX_LSB = 7;
	// color   6..4
	localparam int REC_COLOR_LSB = 4;
	// single valid flag
	localparam int REC_VALID_BIT = 3;
	// octant  2..0
	localparam int REC_OCTANT_LSB = 0;

	// controller states
	typedef enum logic [2:0] {
		// waiting for a frame with object change
		IDLE,
		// background fill in raster order
		CLR_SCREEN,
		// fetch next record or finish the frame
		POP_LINE,
		// record now on the queue output
		RD_LINE,
		// stepping along one line
		GEN_POINTS
	} raster_state_t;

endpackage

// File: logic/line_fifo.sv
/* Line record queue */

module line_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input raster_pkg::line_rec_t wr_data,
	output logic full,
	input logic rd_en,
	output raster_pkg::line_rec_t rd_data,
	output logic empty
);
	import raster_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);

	// record storage
	line_rec_t mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_wr;
	logic do_rd;

	// drop writes when full, drop reads when empty
	assign do_wr = wr_en & ~full;
	assign do_rd = rd_en & ~empty;

	assign full = (count == CNT_W'(FIFO_DEPTH));
	assign empty = (count == '0);

	// pointers wrap at the last slot, depth need not be a power of two
	always_ff @(posedge clk) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			// occupancy, simultaneous push and pop cancel out
			if (do_wr & ~do_rd)
				count <= count + 1'b1;
			else if (do_rd & ~do_wr)
				count <= count - 1'b1;
		end
	end

	// storage write and registered read port
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
		// holds the popped record until the next pop
		if (do_rd)
			rd_data <= mem[rd_ptr];
	end

endmodule

// File: logic/screen_scan.sv
/* Clear pass scan counter */

module screen_scan #(
	parameter int SCREEN_W = 640,
	parameter int SCREEN_H = 480
) (
	input logic clk,
	input logic rst,
	input logic clr_coords,
	input logic advance,
	output raster_pkg::coord_t scan_x,
	output raster_pkg::row_t scan_y,
	output logic last_px
);
	import raster_pkg::*;

	// right edge column and bottom row
	localparam coord_t LAST_X = coord_t'(SCREEN_W - 1);
	localparam row_t LAST_Y = row_t'(SCREEN_H - 1);

	logic end_of_row;

	assign end_of_row = (scan_x == LAST_X);
	// bottom right corner ends the pass
	assign last_px = end_of_row & (scan_y == LAST_Y);

	// raster order walk, x fast and y slow
	always_ff @(posedge clk) begin
		if (!rst) begin
			scan_x <= '0;
			scan_y <= '0;
		end else if (clr_coords) begin
			scan_x <= '0;
			scan_y <= '0;
		end else if (advance) begin
			if (end_of_row) begin
				scan_x <= '0;
				// wrap back to the top after the last pixel
				if (last_px)
					scan_y <= '0;
				else
					scan_y <= scan_y + 1'b1;
			end else begin
				scan_x <= scan_x + 1'b1;
			end
		end
	end

endmodule

// File: logic/point_gen.sv
/* Bresenham point stepper */

module point_gen (
	input logic clk,
	input logic rst,
	input logic start,
	input logic step,
	input raster_pkg::delta_t dx,
	input raster_pkg::delta_t dy,
	output raster_pkg::coord_t off_x,
	output raster_pkg::coord_t off_y
);
	import raster_pkg::*;

	// two extra bits cover 2dy - 2dx and the error swing
	localparam int DW = $bits(delta_t);
	localparam int ERR_W = DW + 2;

	logic signed [ERR_W-1:0] dx_ext;
	logic signed [ERR_W-1:0] dy_ext;
	logic signed [ERR_W-1:0] err;
	// error increments, flat step and diagonal step
	logic signed [ERR_W-1:0] inc_flat;
	logic signed [ERR_W-1:0] inc_diag;

	// sign extend the deltas to error width
	assign dx_ext = {{(ERR_W - DW){dx[DW-1]}}, dx};
	assign dy_ext = {{(ERR_W - DW){dy[DW-1]}}, dy};

	// increments fixed for the whole line
	always_ff @(posedge clk) begin
		if (start) begin
			inc_flat <= dy_ext <<< 1;
			inc_diag <= (dy_ext - dx_ext) <<< 1;
		end
	end

	// offset from the start point and the running error
	always_ff @(posedge clk) begin
		if (!rst) begin
			off_x <= '0;
			off_y <= '0;
			err <= '0;
		end else if (start) begin
			off_x <= '0;
			off_y <= '0;
			// initial decision value 2dy - dx
			err <= (dy_ext <<< 1) - dx_ext;
		end else if (step) begin
			// first octant, x always moves
			off_x <= off_x + coord_t'(1);
			if (err > 0) begin
				off_y <= off_y + coord_t'(1);
				err <= err + inc_diag;
			end else begin
				err <= err + inc_flat;
			end
		end
	end

endmodule

// File: logic/line_generator.sv
/* Rasterizer controller */

module line_generator (
	input logic clk,
	input logic rst,
	input raster_pkg::line_rec_t fifo_data,
	input logic fifo_empty,
	output logic fifo_rd_en,
	input logic end_of_objects,
	input logic frame_start,
	input logic obj_change,
	input raster_pkg::color_t bk_color,
	input logic frame_ready,
	input raster_pkg::coord_t scan_x,
	input raster_pkg::row_t scan_y,
	input logic last_px,
	output logic clr_coords,
	output logic advance,
	input raster_pkg::coord_t off_x,
	input raster_pkg::coord_t off_y,
	output logic pt_start,
	output logic pt_step,
	output raster_pkg::delta_t line_dx,
	output raster_pkg::delta_t line_dy,
	output logic raster_done,
	output logic px_valid,
	output raster_pkg::coord_t px_x,
	output raster_pkg::row_t px_y,
	output raster_pkg::color_t px_color,
	output logic clr_color,
	output raster_pkg::octant_t octant
);
	import raster_pkg::*;

	localparam int CW = $bits(coord_t);

	raster_state_t state;
	raster_state_t nxt_state;

	// line capture register, filled when a valid record is read
	line_rec_t cap;

	logic rec_valid;
	logic load_line;
	coord_t x_init;
	coord_t y_init;
	coord_t x_final;
	coord_t y_final;
	coord_t cur_x;
	coord_t cur_y;
	logic final_point;

	// valid flag straight from the queue output
	assign rec_valid = fifo_data[REC_VALID_BIT];

	// deltas go to the stepper from the queue output
	// the record stays there until the next pop
	assign line_dx = fifo_data[REC_DX_LSB +: $bits(delta_t)];
	assign line_dy = fifo_data[REC_DY_LSB +: $bits(delta_t)];

	always_ff @(posedge clk) begin
		if (load_line)
			cap <= fifo_data;
	end

	// end points of the captured line
	assign x_init = cap[REC_X_INIT_LSB +: CW];
	assign y_init = cap[REC_Y_INIT_LSB +: CW];
	assign x_final = cap[REC_X_FINAL_LSB +: CW];
	assign y_final = cap[REC_Y_FINAL_LSB +: CW];

	// absolute point = start point + stepper offset
	assign cur_x = x_init + off_x;
	assign cur_y = y_init + off_y;
	assign final_point = (cur_x == x_final) & (cur_y == y_final);

	// pixel source, scan position during the clear, line point otherwise
	assign px_x = clr_color ? scan_x : cur_x;
	assign px_y = clr_color ? scan_y : row_t'(cur_y);
	assign px_color = clr_color ? bk_color : cap[REC_COLOR_LSB +: $bits(color_t)];
	assign octant = cap[REC_OCTANT_LSB +: $bits(octant_t)];

	always_ff @(posedge clk) begin
		if (!rst)
			state <= IDLE;
		else
			state <= nxt_state;
	end

	always_comb begin
		nxt_state = state;
		fifo_rd_en = 1'b0;
		load_line = 1'b0;
		clr_coords = 1'b0;
		advance = 1'b0;
		pt_start = 1'b0;
		pt_step = 1'b0;
		raster_done = 1'b0;
		px_valid = 1'b0;
		clr_color = 1'b0;
		case (state)
			IDLE: begin
				// nothing drawn until the objects change
				if (frame_start & obj_change) begin
					clr_coords = 1'b1;
					nxt_state = CLR_SCREEN;
				end
			end
			CLR_SCREEN: begin
				px_valid = 1'b1;
				clr_color = 1'b1;
				// scan only moves on an accepted pixel
				if (frame_ready) begin
					advance = 1'b1;
					if (last_px)
						nxt_state = POP_LINE;
				end
			end
			POP_LINE: begin
				if (!fifo_empty) begin
					fifo_rd_en = 1'b1;
					nxt_state = RD_LINE;
				end else if (end_of_objects & frame_start) begin
					// queue drained, frame is finished
					raster_done = 1'b1;
					if (obj_change) begin
						clr_coords = 1'b1;
						nxt_state = CLR_SCREEN;
					end else begin
						nxt_state = IDLE;
					end
				end
			end
			RD_LINE: begin
				// invalid records are dropped without a pixel
				if (rec_valid) begin
					load_line = 1'b1;
					pt_start = 1'b1;
					nxt_state = GEN_POINTS;
				end else begin
					nxt_state = POP_LINE;
				end
			end
			GEN_POINTS: begin
				px_valid = 1'b1;
				if (frame_ready) begin
					// end point drawn, fetch the next line
					if (final_point)
						nxt_state = POP_LINE;
					else
						pt_step = 1'b1;
				end
			end
			default: nxt_state = IDLE;
		endcase
	end

endmodule

// File: logic/raster_top.sv
/* Line rasterizer top */

module raster_top #(
	parameter int SCREEN_W = 640,
	parameter int SCREEN_H = 480,
	parameter int FIFO_DEPTH = 16
) (
	input logic clk,
	input logic rst,
	input logic line_wr_en,
	input raster_pkg::line_rec_t line_data,
	output logic line_full,
	input logic frame_start,
	input logic end_of_objects,
	input logic obj_change,
	input raster_pkg::color_t bk_color,
	input logic frame_ready,
	output logic raster_done,
	output logic px_valid,
	output raster_pkg::coord_t px_x,
	output raster_pkg::row_t px_y,
	output raster_pkg::color_t px_color,
	output logic clr_color,
	output raster_pkg::octant_t octant
);
	import raster_pkg::*;

	// queue to controller
	line_rec_t fifo_data;
	logic fifo_empty;
	logic fifo_rd_en;

	// controller to scan counter
	logic clr_coords;
	logic advance;
	coord_t scan_x;
	row_t scan_y;
	logic last_px;

	// controller to point stepper
	logic pt_start;
	logic pt_step;
	delta_t line_dx;
	delta_t line_dy;
	coord_t off_x;
	coord_t off_y;

	line_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk(clk),
		.rst(rst),
		.wr_en(line_wr_en),
		.wr_data(line_data),
		.full(line_full),
		.rd_en(fifo_rd_en),
		.rd_data(fifo_data),
		.empty(fifo_empty)
	);

	screen_scan #(
		.SCREEN_W(SCREEN_W),
		.SCREEN_H(SCREEN_H)
	) u_scan (
		.clk(clk),
		.rst(rst),
		.clr_coords(clr_coords),
		.advance(advance),
		.scan_x(scan_x),
		.scan_y(scan_y),
		.last_px(last_px)
	);

	point_gen u_point (
		.clk(clk),
		.rst(rst),
		.start(pt_start),
		.step(pt_step),
		.dx(line_dx),
		.dy(line_dy),
		.off_x(off_x),
		.off_y(off_y)
	);

	line_generator u_gen (
		.clk(clk),
		.rst(rst),
		.fifo_data(fifo_data),
		.fifo_empty(fifo_empty),
		.fifo_rd_en(fifo_rd_en),
		.end_of_objects(end_of_objects),
		.frame_start(frame_start),
		.obj_change(obj_change),
		.bk_color(bk_color),
		.frame_ready(frame_ready),
		.scan_x(scan_x),
		.scan_y(scan_y),
		.last_px(last_px),
		.clr_coords(clr_coords),
		.advance(advance),
		.off_x(off_x),
		.off_y(off_y),
		.pt_start(pt_start),
		.pt_step(pt_step),
		.line_dx(line_dx),
		.line_dy(line_dy),
		.raster_done(raster_done),
		.px_valid(px_valid),
		.px_x(px_x),
		.px_y(px_y),
		.px_color(px_color),
		.clr_color(clr_color),
		.octant(octant)
	);

endmodule

// File: verif/raster_clk_gen.sv
/* Testbench clock */

module raster_clk_gen #(
	parameter int PERIOD = 20
) (
	output logic clk
);

	// free running, starts low
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

// File: verif/raster_sva.sv
/* Rasterizer bound assertions */

module raster_sva #(
	parameter int SCREEN_W = 640,
	parameter int SCREEN_H = 480
) (
	input logic clk,
	input logic rst,
	input logic frame_ready,
	input logic px_valid,
	input raster_pkg::coord_t px_x,
	input raster_pkg::row_t px_y,
	input raster_pkg::color_t px_color,
	input logic clr_color,
	input raster_pkg::raster_state_t state
);
	import raster_pkg::*;

	// screen limits at port width
	localparam coord_t W_LIM = coord_t'(SCREEN_W);
	localparam row_t H_LIM = row_t'(SCREEN_H);
	// bottom right corner of the clear pass
	localparam coord_t LAST_X = coord_t'(SCREEN_W - 1);
	localparam row_t LAST_Y = row_t'(SCREEN_H - 1);

	// pixel and its position hold while frame_ready is low
	stall_hold: assert property (@(posedge clk) disable iff (!rst)
		px_valid && !frame_ready |=>
		px_valid && $stable(px_x) && $stable(px_y) && $stable(px_color))
		else $error("pixel changed while frame_ready was low");

	// clear pass moves one column per accepted pixel inside a row
	clear_step: assert property (@(posedge clk) disable iff (!rst)
		clr_color && frame_ready && (px_x != LAST_X) |=>
		clr_color && (px_x == $past(px_x) + 1'b1) && (px_y == $past(px_y)))
		else $error("clear pass did not step to the next column");

	// accepted bottom right pixel ends the clear pass
	clear_end: assert property (@(posedge clk) disable iff (!rst)
		clr_color && frame_ready && (px_x == LAST_X) && (px_y == LAST_Y) |=>
		(state == POP_LINE))
		else $error("clear pass did not end after the last pixel");

	// next line point is one column right and at most one row down, or the line is over
	line_step: assert property (@(posedge clk) disable iff (!rst)
		px_valid && !clr_color && frame_ready |=>
		(state == POP_LINE) ||
		((px_x == $past(px_x) + 1'b1) &&
		((px_y == $past(px_y)) || (px_y == $past(px_y) + 1'b1))))
		else $error("line point did not follow the first octant step");

	// every pixel lands on the screen
	on_screen: assert property (@(posedge clk) disable iff (!rst)
		px_valid |-> (px_x < W_LIM) && (px_y < H_LIM))
		else $error("pixel outside the screen");

endmodule

bind raster_top raster_sva #(
	.SCREEN_W(SCREEN_W),
	.SCREEN_H(SCREEN_H)
) i_sva (
	.clk(clk),
	.rst(rst),
	.frame_ready(frame_ready),
	.px_valid(px_valid),
	.px_x(px_x),
	.px_y(px_y),
	.px_color(px_color),
	.clr_color(clr_color),
	.state(u_gen.state)
);

// File: verif/raster_tb.sv
/* Line rasterizer testbench */

module raster_tb;
	import raster_pkg::*;

	localparam int SCREEN_W = 16;
	localparam int SCREEN_H = 8;
	localparam int FIFO_DEPTH = 8;
	localparam int TIMEOUT = 5000;

	logic clk;
	logic rst;
	logic line_wr_en;
	line_rec_t line_data;
	logic line_full;
	logic frame_start;
	logic end_of_objects;
	logic obj_change;
	color_t bk_color;
	logic frame_ready;
	logic raster_done;
	logic px_valid;
	coord_t px_x;
	row_t px_y;
	color_t px_color;
	logic clr_color;
	octant_t octant;

	// frame table read from the vector file
	string frm_name [$];
	int frm_bk [$];
	int frm_chg [$];
	int frm_first [$];
	int frm_nlines [$];
	int frm_count [$];
	line_rec_t rec_tab [$];

	// records in the queue but not drawn yet
	line_rec_t pending [$];

	// expected pixel stream, one entry per accepted pixel
	int exp_x [$];
	int exp_y [$];
	int exp_color [$];
	int exp_clr [$];
	int exp_oct [$];

	string cur_test = "reset";
	int pix_cnt = 0;
	int done_cnt = 0;

	raster_clk_gen #(
		.PERIOD(20)
	) i_clk (
		.clk(clk)
	);

	raster_top #(
		.SCREEN_W(SCREEN_W),
		.SCREEN_H(SCREEN_H),
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_dut (
		.clk(clk),
		.rst(rst),
		.line_wr_en(line_wr_en),
		.line_data(line_data),
		.line_full(line_full),
		.frame_start(frame_start),
		.end_of_objects(end_of_objects),
		.obj_change(obj_change),
		.bk_color(bk_color),
		.frame_ready(frame_ready),
		.raster_done(raster_done),
		.px_valid(px_valid),
		.px_x(px_x),
		.px_y(px_y),
		.px_color(px_color),
		.clr_color(clr_color),
		.octant(octant)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string what, input int expected, input int actual);
		if (expected != actual)
			abort_run($sformatf("Error: test %s, %s expected %0d, actual %0d",
				cur_test, what, expected, actual));
	endtask

	// fields packed at the package positions with deltas from the end points
	function automatic line_rec_t pack_record(input int x0, input int y0, input int x1,
		input int y1, input int color, input int valid, input int oct);
		line_rec_t rec;
		rec = '0;
		rec[REC_X_INIT_LSB +: $bits(coord_t)] = coord_t'(x0);
		rec[REC_Y_INIT_LSB +: $bits(coord_t)] = coord_t'(y0);
		rec[REC_X_FINAL_LSB +: $bits(coord_t)] = coord_t'(x1);
		rec[REC_Y_FINAL_LSB +: $bits(coord_t)] = coord_t'(y1);
		rec[REC_DY_LSB +: $bits(delta_t)] = delta_t'(y1 - y0);
		rec[REC_DX_LSB +: $bits(delta_t)] = delta_t'(x1 - x0);
		rec[REC_COLOR_LSB +: $bits(color_t)] = color_t'(color);
		rec[REC_VALID_BIT] = valid[0];
		rec[REC_OCTANT_LSB +: $bits(octant_t)] = octant_t'(oct);
		return rec;
	endfunction

	task automatic load_vectors();
		int fd;
		int code;
		int n;
		int a;
		int b;
		int c;
		int d;
		int e;
		int v;
		int o;
		string line;
		string name;
		fd = $fopen("verif/raster_vectors.txt", "r");
		if (fd == 0)
			abort_run("cannot open verif/raster_vectors.txt");
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			// comment lines fall through to default
			if (code == 0 || line.len() < 2)
				continue;
			case (line.getc(0))
				"F": begin
					n = $sscanf(line, "F %s %d %d", name, a, b);
					if (n != 3)
						abort_run({"malformed frame line in vector file: ", line});
					frm_name.push_back(name);
					frm_bk.push_back(a);
					frm_chg.push_back(b);
					frm_first.push_back(rec_tab.size());
					frm_nlines.push_back(0);
					frm_count.push_back(0);
				end
				"L": begin
					n = $sscanf(line, "L %d %d %d %d %d %d %d", a, b, c, d, e, v, o);
					if (n != 7 || frm_name.size() == 0)
						abort_run({"malformed line record in vector file: ", line});
					rec_tab.push_back(pack_record(a, b, c, d, e, v, o));
					frm_nlines[frm_nlines.size() - 1] = frm_nlines[frm_nlines.size() - 1] + 1;
				end
				"E": begin
					n = $sscanf(line, "E %d", a);
					if (n != 1 || frm_name.size() == 0)
						abort_run({"malformed pixel count in vector file: ", line});
					frm_count[frm_count.size() - 1] = a;
				end
				default: ;
			endcase
		end
		$fclose(fd);
		if (frm_name.size() == 0)
			abort_run("the vector file holds no frames");
	endtask

	task automatic push_pixel(input int x, input int y, input int color, input int clr,
		input int oct);
		exp_x.push_back(x);
		exp_y.push_back(y);
		exp_color.push_back(color);
		exp_clr.push_back(clr);
		exp_oct.push_back(oct);
	endtask

	// raster order clear, then every pending valid line by Bresenham
	task automatic build_expected(input int bk);
		line_rec_t rec;
		int x;
		int y;
		int x1;
		int y1;
		int dx;
		int dy;
		int err;
		int col;
		int oct;
		int i;
		for (y = 0; y < SCREEN_H; y++)
			for (x = 0; x < SCREEN_W; x++)
				push_pixel(x, y, bk, 1, 0);
		while (pending.size() > 0) begin
			rec = pending.pop_front();
			if (rec[REC_VALID_BIT]) begin
				x = int'(rec[REC_X_INIT_LSB +: $bits(coord_t)]);
				y = int'(rec[REC_Y_INIT_LSB +: $bits(coord_t)]);
				x1 = int'(rec[REC_X_FINAL_LSB +: $bits(coord_t)]);
				y1 = int'(rec[REC_Y_FINAL_LSB +: $bits(coord_t)]);
				col = int'(rec[REC_COLOR_LSB +: $bits(color_t)]);
				oct = int'(rec[REC_OCTANT_LSB +: $bits(octant_t)]);
				dx = x1 - x;
				dy = y1 - y;
				err = 2 * dy - dx;
				push_pixel(x, y, col, 0, oct);
				// dx steps after the start point
				for (i = 0; i < dx; i++) begin
					x = x + 1;
					if (err > 0) begin
						y = y + 1;
						err = err + 2 * dy - 2 * dx;
					end else begin
						err = err + 2 * dy;
					end
					push_pixel(x, y, col, 0, oct);
				end
			end
		end
	endtask

	task automatic wait_not_full();
		int n;
		n = 0;
		while (line_full) begin
			if (n >= TIMEOUT)
				abort_run("timeout waiting for free space in the line queue");
			@(negedge clk);
			n++;
		end
	endtask

	task automatic wait_clear_start();
		int n;
		n = 0;
		while (!(px_valid && clr_color)) begin
			if (n >= TIMEOUT)
				abort_run("timeout waiting for the clear pass to start");
			@(negedge clk);
			n++;
		end
	endtask

	task automatic wait_done(input int base);
		int n;
		n = 0;
		while (done_cnt == base) begin
			if (n >= TIMEOUT)
				abort_run("timeout waiting for raster_done");
			@(negedge clk);
			n++;
		end
	endtask

	task automatic run_frame(input int f);
		int i;
		int pix_base;
		int done_base;
		cur_test = frm_name[f];
		@(negedge clk);
		bk_color = color_t'(frm_bk[f]);
		// fill the queue before the frame starts
		for (i = 0; i < frm_nlines[f]; i++) begin
			wait_not_full();
			line_wr_en = 1'b1;
			line_data = rec_tab[frm_first[f] + i];
			pending.push_back(rec_tab[frm_first[f] + i]);
			@(negedge clk);
		end
		line_wr_en = 1'b0;
		pix_base = pix_cnt;
		done_base = done_cnt;
		if (frm_chg[f] != 0) begin
			build_expected(frm_bk[f]);
			check_value("model pixel count", frm_count[f], exp_x.size());
			frame_start = 1'b1;
			end_of_objects = 1'b1;
			obj_change = 1'b1;
			wait_clear_start();
			// dropped so the frame ends in idle
			obj_change = 1'b0;
			wait_done(done_base);
			// no stray pixel once the frame is over
			repeat (20) begin
				@(negedge clk);
				check_value("px_valid after done", 0, int'(px_valid));
			end
		end else begin
			frame_start = 1'b1;
			end_of_objects = 1'b1;
			// idle holds while the objects are unchanged
			repeat (100) begin
				@(negedge clk);
				check_value("px_valid in idle", 0, int'(px_valid));
				check_value("raster_done in idle", 0, int'(raster_done));
				check_value("clr_color in idle", 0, int'(clr_color));
			end
		end
		check_value("frame pixel count", frm_count[f], pix_cnt - pix_base);
		check_value("raster_done pulses", (frm_chg[f] != 0) ? 1 : 0, done_cnt - done_base);
		frame_start = 1'b0;
		end_of_objects = 1'b0;
		@(negedge clk);
	endtask

	// random back-pressure at about 70 % ready
	initial begin : ready_driver
		frame_ready = 1'b0;
		void'($urandom(32'h8015));
		forever begin
			@(negedge clk);
			frame_ready = ($urandom % 100) < 70;
		end
	end

	// accepted pixels against the expected stream
	always @(posedge clk) begin : pixel_monitor
		int eoct;
		int eclr;
		if (rst) begin
			if (px_valid && frame_ready) begin
				pix_cnt = pix_cnt + 1;
				if (exp_x.size() == 0) begin
					abort_run("a pixel was accepted while none was expected");
				end else begin
					check_value("px_x", exp_x.pop_front(), int'(px_x));
					check_value("px_y", exp_y.pop_front(), int'(px_y));
					check_value("px_color", exp_color.pop_front(), int'(px_color));
					eclr = exp_clr.pop_front();
					eoct = exp_oct.pop_front();
					check_value("clr_color", eclr, int'(clr_color));
					// octant only means something on line pixels
					if (eclr == 0)
						check_value("octant", eoct, int'(octant));
				end
			end
			if (raster_done) begin
				done_cnt = done_cnt + 1;
				if (exp_x.size() != 0)
					abort_run("raster_done came before the last expected pixel");
			end
		end
	end

	initial begin : main_seq
		int f;
		rst = 1'b0;
		line_wr_en = 1'b0;
		line_data = '0;
		frame_start = 1'b0;
		end_of_objects = 1'b0;
		obj_change = 1'b0;
		bk_color = '0;
		load_vectors();
		repeat (10) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		check_value("px_valid after reset", 0, int'(px_valid));
		check_value("raster_done after reset", 0, int'(raster_done));
		check_value("clr_color after reset", 0, int'(clr_color));
		check_value("line_full after reset", 0, int'(line_full));
		for (f = 0; f < frm_name.size(); f++)
			run_frame(f);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: verif/raster_vectors.txt
# F name bk_color obj_change | L x0 y0 x1 y1 color valid octant | E expected pixel count
# lines are first octant, 0 <= y1-y0 <= x1-x0, screen 16 x 8
F idle_no_change 1 0
E 0
F frame_lines 5 1
L 2 1 12 1 3 1 0
L 0 0 7 7 6 1 1
L 1 2 14 6 2 1 2
L 9 4 9 4 7 1 3
L 0 7 15 7 1 0 4
L 3 5 10 7 4 1 5
E 170
F frame_redraw 2 1
L 0 7 15 7 5 1 6
L 4 0 11 3 1 1 7
L 2 2 8 6 0 0 2
L 15 0 15 0 3 1 0
E 153
F no_change 4 0
E 0
F clear_only 7 1
E 128

// File: files.f
logic/raster_pkg.sv
logic/line_fifo.sv
logic/screen_scan.sv
logic/point_gen.sv
logic/line_generator.sv
logic/raster_top.sv
verif/raster_clk_gen.sv
verif/raster_sva.sv
verif/raster_tb.sv

// File: Makefile
# Verilator build and run for the line rasterizer

VERILATOR ?= verilator
TOP ?= raster_tb
FILE_LIST ?= files.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= Simulation completed successfully

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

# pass only if the pass message shows up in the output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
